// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := raster_tb
FILELIST := vlog.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := *** TEST FAILED ***
PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "no result found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/raster_stimulus.txt ====
# C opcode x0 y0 x1 y1 x2 y2 colour_hex expected_count (0 nop, 1 set colour, 2 triangle, 3 clear)
# R address expected_data_hex, W waits for o_ready and checks the job count
C 3 0 0 0 0 0 0 00 256
W
R 0 00
R 137 00
R 255 00
C 1 0 0 0 0 0 0 5a 0
C 2 3 2 8 4 5 6 00 30
W
R 35 5a
R 104 5a
R 34 00
R 73 00
R 117 00
C 1 0 0 0 0 0 0 c3 0
C 2 -3 10 20 12 4 30 00 96
W
R 160 c3
R 255 c3
R 159 00
C 2 -10 -5 -2 -8 -4 -1 00 0
W
R 0 00
R 35 5a
C 2 2 8 6 8 4 8 00 5
C 2 0 0 15 0 0 3 00 64
W
R 130 c3
R 134 c3
R 129 00
R 135 00
R 0 00
R 26 00
C 0 0 0 15 15 0 0 ff 0
C 1 0 0 0 0 0 0 3e 0
W
R 35 5a
R 130 c3
C 2 12 0 13 1 12 1 00 4
W
R 12 3e
R 29 3e
R 14 00

// ==== bench/raster_tb.sv ====
`timescale 1ns/1ps

module raster_tb
    import raster_geom_pkg::*;
    import raster_cmd_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    // eleven commands at the worst-case job length of FB_SIZE + FB_H + 4 cycles, plus margin
    localparam int MAX_CYCLES = 4000;
    localparam string STIM_FILE = "bench/raster_stimulus.txt";

    logic                      clk;
    logic                      rst;
    logic                      i_cmd_valid;
    opcode_t                   i_opcode;
    logic signed [COORD_W-1:0] i_x0, i_y0, i_x1, i_y1, i_x2, i_y2;
    logic [PIX_W-1:0]          i_color;
    logic [ADDR_W-1:0]         i_rd_addr;
    logic                      o_ready;
    logic                      o_done;
    logic [CNT_W-1:0]          o_pixel_count;
    logic [PIX_W-1:0]          o_rd_data;

    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int test_num = 0;
    int test_checks = 0;
    int test_errors = 0;
    int jobs_started = 0;
    int dones_seen = 0;
    int done_pixels = 0;
    int expected_count = 0;

    raster_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: stimulus not finished after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // the count is captured in the middle of the done cycle, where it is settled
    always @(negedge clk) begin
        if (!rst && o_done) begin
            dones_seen = dones_seen + 1;
            done_pixels = int'(o_pixel_count);
        end
    end

    function automatic int smaller(input int a, input int b);
        return (a < b) ? a : b;
    endfunction

    function automatic int larger(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    // area of the bounding box after clamping to the frame, zero when nothing is left
    function automatic int box_pixel_count(input int x0, input int y0, input int x1,
                                           input int y1, input int x2, input int y2);
        int lo_x, hi_x, lo_y, hi_y;
        lo_x = larger(smaller(smaller(x0, x1), x2), 0);
        hi_x = smaller(larger(larger(x0, x1), x2), FB_W - 1);
        lo_y = larger(smaller(smaller(y0, y1), y2), 0);
        hi_y = smaller(larger(larger(y0, y1), y2), FB_H - 1);
        if (lo_x > hi_x || lo_y > hi_y) begin
            return 0;
        end
        return (hi_x - lo_x + 1) * (hi_y - lo_y + 1);
    endfunction

    task automatic check_value(input string name, input int actual, input int expected);
        checks++;
        test_checks++;
        assert (actual == expected) else begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_condition(input bit cond, input string what);
        checks++;
        test_checks++;
        assert (cond) else begin
            $display("Error at %0t: %s", $time, what);
            errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test();
        $display("test %0d finished: %0d checks, %0d errors", test_num, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // strobes one command for a single cycle, whether or not the DUT is ready
    task automatic send_command(input int op, input int x0, input int y0, input int x1,
                                input int y1, input int x2, input int y2,
                                input int color, input int file_count);
        opcode_t code;
        bit      accepted;
        int      rule_count;
        code = opcode_t'(op[1:0]);
        if (code == OP_TRIANGLE || code == OP_CLEAR) begin
            if (code == OP_CLEAR) begin
                rule_count = box_pixel_count(0, 0, FB_W - 1, 0, 0, FB_H - 1);
            end else begin
                rule_count = box_pixel_count(x0, y0, x1, y1, x2, y2);
            end
            check_condition(rule_count == file_count,
                $sformatf("stimulus count %0d disagrees with the box rule, which gives %0d",
                          file_count, rule_count));
        end
        i_opcode = code;
        i_x0 = COORD_W'(x0);
        i_y0 = COORD_W'(y0);
        i_x1 = COORD_W'(x1);
        i_y1 = COORD_W'(y1);
        i_x2 = COORD_W'(x2);
        i_y2 = COORD_W'(y2);
        i_color = PIX_W'(color);
        i_cmd_valid = 1'b1;
        accepted = o_ready;
        if (accepted && (code == OP_TRIANGLE || code == OP_CLEAR)) begin
            jobs_started++;
            expected_count = file_count;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        i_cmd_valid = 1'b0;
    endtask

    task automatic wait_ready();
        while (!o_ready) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        check_condition(dones_seen >= jobs_started, "o_done never rose for the last job");
        check_condition(dones_seen <= jobs_started, "o_done pulsed with no job running");
        if (jobs_started > 0) begin
            check_value("o_pixel_count", done_pixels, expected_count);
        end
    endtask

    task automatic read_back(input int addr, input int expected);
        i_rd_addr = ADDR_W'(addr);
        @(posedge clk);
        #DRIVE_DELAY;
        check_value($sformatf("o_rd_data[%0d]", addr), int'(o_rd_data), expected);
    endtask

    initial begin
        int    fd;
        int    n;
        int    op, x0, y0, x1, y1, x2, y2, color, count, addr, data;
        bit    prev_cmd;
        string line;
        string rest;
        rst = 1'b1;
        i_cmd_valid = 1'b0;
        i_opcode = OP_NOP;
        i_x0 = '0;
        i_y0 = '0;
        i_x1 = '0;
        i_y1 = '0;
        i_x2 = '0;
        i_y2 = '0;
        i_color = '0;
        i_rd_addr = '0;
        prev_cmd = 1'b0;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        // these belong to the first test, which is reported with the clear
        check_condition(o_ready == 1'b1, "o_ready is not high after reset");
        check_condition(o_done == 1'b0, "o_done is not low after reset");

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Error: cannot open %s", STIM_FILE);
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 1) begin
                    continue;
                end
                rest = line.substr(1, line.len() - 1);
                if (line[0] == "C") begin
                    // a run of back-to-back commands opens a new test
                    if (!prev_cmd) begin
                        if (test_num > 0) begin
                            finish_test();
                        end
                        test_num++;
                    end
                    n = $sscanf(rest, "%d %d %d %d %d %d %d %h %d",
                                op, x0, y0, x1, y1, x2, y2, color, count);
                    check_condition(n == 9, {"unreadable command line: ", line});
                    if (n == 9) begin
                        send_command(op, x0, y0, x1, y1, x2, y2, color, count);
                    end
                    prev_cmd = 1'b1;
                end else if (line[0] == "R") begin
                    n = $sscanf(rest, "%d %h", addr, data);
                    check_condition(n == 2, {"unreadable readback line: ", line});
                    if (n == 2) begin
                        read_back(addr, data);
                    end
                    prev_cmd = 1'b0;
                end else if (line[0] == "W") begin
                    wait_ready();
                    prev_cmd = 1'b0;
                end
            end
            $fclose(fd);
            finish_test();
        end

        $display("summary: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog/bbox_rasterizer.sv ====
`timescale 1ns/1ps

module bbox_rasterizer
    import raster_geom_pkg::*;
    import raster_cmd_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_start,
    input  logic signed [COORD_W-1:0] i_x0,
    input  logic signed [COORD_W-1:0] i_y0,
    input  logic signed [COORD_W-1:0] i_x1,
    input  logic signed [COORD_W-1:0] i_y1,
    input  logic signed [COORD_W-1:0] i_x2,
    input  logic signed [COORD_W-1:0] i_y2,
    output logic                      o_wr_en,
    output logic [ADDR_W-1:0]         o_wr_addr,
    output logic                      o_done
);

    rast_state_t state;

    // unclamped and clamped box straight from the vertex inputs
    logic signed [COORD_W-1:0] raw_min_x, raw_max_x, raw_min_y, raw_max_y;
    logic signed [COORD_W-1:0] clp_min_x, clp_max_x, clp_min_y, clp_max_y;
    logic                      box_valid;

    // box captured in VERIFY and held for the rest of the job
    logic signed [COORD_W-1:0] box_min_x, box_max_x, box_min_y, box_max_y;

    // current pixel position while walking the box
    logic signed [COORD_W-1:0] x, y;

    // added to the address after a row to land on the next row's first pixel
    logic [ADDR_W-1:0] line_jump;

    function automatic logic signed [COORD_W-1:0] min3(
        input logic signed [COORD_W-1:0] a,
        input logic signed [COORD_W-1:0] b,
        input logic signed [COORD_W-1:0] c
    );
        logic signed [COORD_W-1:0] ab;
        ab = (a < b) ? a : b;
        return (ab < c) ? ab : c;
    endfunction

    function automatic logic signed [COORD_W-1:0] max3(
        input logic signed [COORD_W-1:0] a,
        input logic signed [COORD_W-1:0] b,
        input logic signed [COORD_W-1:0] c
    );
        logic signed [COORD_W-1:0] ab;
        ab = (a > b) ? a : b;
        return (ab > c) ? ab : c;
    endfunction

    always_comb begin
        raw_min_x = min3(i_x0, i_x1, i_x2);
        raw_max_x = max3(i_x0, i_x1, i_x2);
        raw_min_y = min3(i_y0, i_y1, i_y2);
        raw_max_y = max3(i_y0, i_y1, i_y2);

        clp_min_x = (raw_min_x < 0) ? '0 : raw_min_x;
        clp_max_x = (raw_max_x > X_LAST) ? X_LAST : raw_max_x;
        clp_min_y = (raw_min_y < 0) ? '0 : raw_min_y;
        clp_max_y = (raw_max_y > Y_LAST) ? Y_LAST : raw_max_y;

        // a single row or column is still a valid box
        box_valid = (clp_min_x <= clp_max_x) && (clp_min_y <= clp_max_y);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            o_wr_en <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        state <= ST_VERIFY;
                    end
                end
                ST_VERIFY: begin
                    if (box_valid) begin
                        state <= ST_INIT;
                    end else begin
                        o_done <= 1'b1;
                        state  <= ST_DONE;
                    end
                end
                ST_INIT: begin
                    o_wr_en <= 1'b1;
                    state   <= ST_DRAW;
                end
                ST_DRAW: begin
                    // the last pixel of the row is written in this cycle
                    if (x >= box_max_x) begin
                        o_wr_en <= 1'b0;
                        state   <= ST_NEW_LINE;
                    end
                end
                ST_NEW_LINE: begin
                    if (y < box_max_y) begin
                        o_wr_en <= 1'b1;
                        state   <= ST_DRAW;
                    end else begin
                        o_done <= 1'b1;
                        state  <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    o_done <= 1'b0;
                    state  <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // the address always steps with x, so after a row it sits one past the row's end
    always_ff @(posedge clk) begin
        case (state)
            ST_VERIFY: begin
                box_min_x <= clp_min_x;
                box_max_x <= clp_max_x;
                box_min_y <= clp_min_y;
                box_max_y <= clp_max_y;
            end
            ST_INIT: begin
                x         <= box_min_x;
                y         <= box_min_y;
                o_wr_addr <= ADDR_W'(box_min_y) * ADDR_W'(FB_W) + ADDR_W'(box_min_x);
                line_jump <= ADDR_W'(FB_W)
                             - (ADDR_W'(box_max_x) - ADDR_W'(box_min_x) + ADDR_W'(1));
            end
            ST_DRAW: begin
                x         <= x + COORD_W'(1);
                o_wr_addr <= o_wr_addr + ADDR_W'(1);
            end
            ST_NEW_LINE: begin
                x         <= box_min_x;
                y         <= y + COORD_W'(1);
                o_wr_addr <= o_wr_addr + line_jump;
            end
            default: begin
            end
        endcase
    end

    // every write lies in the clamped box and its address matches the pixel position
    a_wr_in_box: assert property (@(posedge clk) disable iff (rst)
        o_wr_en |-> ((x >= box_min_x) && (x <= box_max_x)
                     && (y >= box_min_y) && (y <= box_max_y)
                     && (o_wr_addr == ADDR_W'(y) * ADDR_W'(FB_W) + ADDR_W'(x))))
        else $error("write address %0d does not match pixel (%0d, %0d) in the box",
                    o_wr_addr, x, y);

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        o_done |=> !o_done)
        else $error("o_done held for more than one cycle");

endmodule

// ==== verilog/cmd_decoder.sv ====
`timescale 1ns/1ps

module cmd_decoder
    import raster_geom_pkg::*;
    import raster_cmd_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_cmd_valid,
    input  opcode_t                   i_opcode,
    input  logic signed [COORD_W-1:0] i_x0,
    input  logic signed [COORD_W-1:0] i_y0,
    input  logic signed [COORD_W-1:0] i_x1,
    input  logic signed [COORD_W-1:0] i_y1,
    input  logic signed [COORD_W-1:0] i_x2,
    input  logic signed [COORD_W-1:0] i_y2,
    input  logic [PIX_W-1:0]          i_color,
    input  logic                      i_job_done,
    output logic                      o_ready,
    output logic                      o_start,
    output logic signed [COORD_W-1:0] o_x0,
    output logic signed [COORD_W-1:0] o_y0,
    output logic signed [COORD_W-1:0] o_x1,
    output logic signed [COORD_W-1:0] o_y1,
    output logic signed [COORD_W-1:0] o_x2,
    output logic signed [COORD_W-1:0] o_y2,
    output logic [PIX_W-1:0]          o_color
);

    logic             busy;
    logic             accept;
    logic             launch;
    logic             set_color;
    logic [PIX_W-1:0] color_reg;

    assign o_ready = ~busy;
    assign accept  = i_cmd_valid & ~busy;

    always_comb begin
        launch    = 1'b0;
        set_color = 1'b0;
        case (i_opcode)
            OP_SET_COLOR: set_color = accept;
            OP_TRIANGLE:  launch    = accept;
            OP_CLEAR:     launch    = accept;
            default:      launch    = 1'b0;
        endcase
    end

    // busy spans from the start pulse to the writer's completion
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            o_start   <= 1'b0;
            color_reg <= '0;
        end else begin
            o_start <= launch;
            if (launch) begin
                busy <= 1'b1;
            end else if (i_job_done) begin
                busy <= 1'b0;
            end
            if (set_color) begin
                color_reg <= i_color;
            end
        end
    end

    // clear is a triangle whose bounding box is the whole frame, drawn in colour 0
    always_ff @(posedge clk) begin
        if (launch) begin
            if (i_opcode == OP_CLEAR) begin
                o_x0    <= '0;
                o_y0    <= '0;
                o_x1    <= X_LAST;
                o_y1    <= '0;
                o_x2    <= '0;
                o_y2    <= Y_LAST;
                o_color <= '0;
            end else begin
                o_x0    <= i_x0;
                o_y0    <= i_y0;
                o_x1    <= i_x1;
                o_y1    <= i_y1;
                o_x2    <= i_x2;
                o_y2    <= i_y2;
                o_color <= color_reg;
            end
        end
    end

    // the writer only reports completion for a job that this decoder started
    a_done_while_busy: assert property (@(posedge clk) disable iff (rst)
        i_job_done |-> busy)
        else $error("job completion arrived while no job was running");

endmodule

// ==== verilog/fb_writer.sv ====
`timescale 1ns/1ps

module fb_writer
    import raster_geom_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              i_start,
    input  logic              i_wr_en,
    input  logic [ADDR_W-1:0] i_wr_addr,
    input  logic [PIX_W-1:0]  i_color,
    input  logic              i_done,
    input  logic [ADDR_W-1:0] i_rd_addr,
    output logic [PIX_W-1:0]  o_rd_data,
    output logic [CNT_W-1:0]  o_pixel_count,
    output logic              o_job_done
);

    // one byte per pixel, row-major, contents undefined until the first clear
    logic [PIX_W-1:0] mem [FB_SIZE];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_color;
        end
    end

    // registered read port, one cycle of latency
    always_ff @(posedge clk) begin
        o_rd_data <= mem[i_rd_addr];
    end

    // start and the first write of a job are always at least two cycles apart
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_pixel_count <= '0;
        end else if (i_start) begin
            o_pixel_count <= '0;
        end else if (i_wr_en) begin
            o_pixel_count <= o_pixel_count + CNT_W'(1);
        end
    end

    // completion trails the rasterizer's done by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_job_done <= 1'b0;
        end else begin
            o_job_done <= i_done;
        end
    end

endmodule

// ==== verilog/raster_cmd_pkg.sv ====
package raster_cmd_pkg;

    // command opcodes accepted by the decoder
    typedef enum logic [1:0] {
        OP_NOP       = 2'd0,
        OP_SET_COLOR = 2'd1,
        OP_TRIANGLE  = 2'd2,
        OP_CLEAR     = 2'd3
    } opcode_t;

    // rasterizer FSM states
    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_VERIFY   = 3'd1,
        ST_INIT     = 3'd2,
        ST_DRAW     = 3'd3,
        ST_NEW_LINE = 3'd4,
        ST_DONE     = 3'd5
    } rast_state_t;

endpackage

// ==== verilog/raster_geom_pkg.sv ====
package raster_geom_pkg;

    // signed vertex coordinates, wide enough for off-screen vertices
    localparam int COORD_W = 8;

    // framebuffer dimensions in pixels
    localparam int FB_W = 16;
    localparam int FB_H = 16;
    localparam int FB_SIZE = FB_W * FB_H;

    // framebuffer address, one address per pixel in row-major order
    localparam int ADDR_W = 8;

    // colour depth of a pixel
    localparam int PIX_W = 8;

    // one bit wider than ADDR_W so a full-frame job count of 256 fits
    localparam int CNT_W = 9;

    // last valid column and row, used for clamping and for clear
    localparam logic signed [COORD_W-1:0] X_LAST = COORD_W'(FB_W - 1);
    localparam logic signed [COORD_W-1:0] Y_LAST = COORD_W'(FB_H - 1);

endpackage

// ==== verilog/raster_top.sv ====
`timescale 1ns/1ps

module raster_top
    import raster_geom_pkg::*;
    import raster_cmd_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_cmd_valid,
    input  opcode_t                   i_opcode,
    input  logic signed [COORD_W-1:0] i_x0,
    input  logic signed [COORD_W-1:0] i_y0,
    input  logic signed [COORD_W-1:0] i_x1,
    input  logic signed [COORD_W-1:0] i_y1,
    input  logic signed [COORD_W-1:0] i_x2,
    input  logic signed [COORD_W-1:0] i_y2,
    input  logic [PIX_W-1:0]          i_color,
    input  logic [ADDR_W-1:0]         i_rd_addr,
    output logic                      o_ready,
    output logic                      o_done,
    output logic [CNT_W-1:0]          o_pixel_count,
    output logic [PIX_W-1:0]          o_rd_data
);

    logic                      start;
    logic signed [COORD_W-1:0] vx0, vy0, vx1, vy1, vx2, vy2;
    logic [PIX_W-1:0]          job_color;
    logic                      wr_en;
    logic [ADDR_W-1:0]         wr_addr;
    logic                      rast_done;

    cmd_decoder u_decoder (
        .clk(clk), .rst(rst), .i_cmd_valid(i_cmd_valid), .i_opcode(i_opcode),
        .i_x0(i_x0), .i_y0(i_y0), .i_x1(i_x1), .i_y1(i_y1), .i_x2(i_x2), .i_y2(i_y2),
        .i_color(i_color), .i_job_done(o_done), .o_ready(o_ready), .o_start(start),
        .o_x0(vx0), .o_y0(vy0), .o_x1(vx1), .o_y1(vy1), .o_x2(vx2), .o_y2(vy2),
        .o_color(job_color)
    );

    bbox_rasterizer u_rasterizer (
        .clk(clk), .rst(rst), .i_start(start),
        .i_x0(vx0), .i_y0(vy0), .i_x1(vx1), .i_y1(vy1), .i_x2(vx2), .i_y2(vy2),
        .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_done(rast_done)
    );

    fb_writer u_writer (
        .clk(clk), .rst(rst), .i_start(start), .i_wr_en(wr_en), .i_wr_addr(wr_addr),
        .i_color(job_color), .i_done(rast_done), .i_rd_addr(i_rd_addr),
        .o_rd_data(o_rd_data), .o_pixel_count(o_pixel_count), .o_job_done(o_done)
    );

endmodule

// ==== vlog.f ====
verilog/raster_geom_pkg.sv
verilog/raster_cmd_pkg.sv
verilog/cmd_decoder.sv
verilog/bbox_rasterizer.sv
verilog/fb_writer.sv
verilog/raster_top.sv
bench/raster_tb.sv
